//--- clio_cfg.svh
/*
 * clio register file configuration
 * revision word, bad-read marker, reset values and block address ranges
 */
`ifndef CLIO_CFG_SVH
`define CLIO_CFG_SVH

// fixed words
`define CLIO_REVISION     32'h0202_0000 // version in high byte
`define CLIO_BAD_READ     32'hBADA_CCE5 // returned for unmapped reads
`define CLIO_EXPCTL_RESET 32'h0000_0080 // cpu owns the expansion bus

// storage sizes
`define CLIO_TIMER_PAIRS  16            // count/backup pairs
`define CLIO_SLACK_BITS   10            // slack keeps low bits only

// byte address ranges, inclusive
`define CLIO_IRQ_BASE     16'h0040      // irq0 set
`define CLIO_IRQ_LAST     16'h007C      // end of interrupt window
`define CLIO_TMR_BASE     16'h0100      // timer_count_0
`define CLIO_TMR_LAST     16'h017C      // timer_backup_15
`define CLIO_TCTRL_BASE   16'h0200      // timer ctrl low set
`define CLIO_TCTRL_LAST   16'h020C      // timer ctrl high clear

`endif

//--- clio_pkg.sv
/*
 * clio shared types
 * bus words, cpu word addresses and per-block word offsets
 */
package clio_pkg;

	// cpu data bus word
	typedef logic [31:0] clio_word_t;

	// cpu word address, byte address bits 15..2
	typedef logic [13:0] clio_addr_t;

	// word offset inside 0x000..0x7fc, byte address bits 10..2
	typedef logic [8:0] clio_off_t;

endpackage

//--- clio_reg_if.sv
/*
 * clio register block bus
 * one write strobe, offset and data out to a block, read data and hit back
 */
`timescale 1ns/10ps

interface clio_reg_if import clio_pkg::*; ();

	logic       wr;     // write strobe, this block only
	clio_off_t  off;    // word offset in the 2k window
	clio_word_t wdata;  // cpu write data
	clio_word_t rdata;  // register contents at off
	logic       hit;    // block owns off

	modport decode (
		output wr, off, wdata,
		input  rdata, hit
	);

	modport block (
		input  wr, off, wdata,
		output rdata, hit
	);

endinterface

//--- clio_addr_decode.sv
/*
 * clio address decoder
 * steers the cpu write strobe to one register block and muxes read data back
 */
`timescale 1ns/10ps
`include "clio_cfg.svh"

module clio_addr_decode import clio_pkg::*; (
	input  clio_addr_t     cpu_addr,
	input  clio_word_t     cpu_din,
	input  logic           cpu_wr,
	output clio_word_t     cpu_dout,
	clio_reg_if.decode     sys_bus,
	clio_reg_if.decode     irq_bus,
	clio_reg_if.decode     tmr_bus
);

	logic [15:0] byte_addr; // cpu byte address
	logic        in_window; // inside the 2k register window
	logic        irq_range;
	logic        tmr_range;
	logic        irq_sel;
	logic        tmr_sel;
	logic        sys_sel;

	assign byte_addr = {cpu_addr, 2'b00};
	assign in_window = (cpu_addr[13:9] == 5'd0); // byte bits 15..11 clear

	assign irq_range = (byte_addr >= `CLIO_IRQ_BASE) && (byte_addr <= `CLIO_IRQ_LAST);
	assign tmr_range = ((byte_addr >= `CLIO_TMR_BASE) && (byte_addr <= `CLIO_TMR_LAST)) ||
		((byte_addr >= `CLIO_TCTRL_BASE) && (byte_addr <= `CLIO_TCTRL_LAST));

	// spare sits inside the interrupt window, so words the irq block
	// does not claim fall through to the system block
	assign irq_sel = in_window & irq_range & irq_bus.hit;
	assign tmr_sel = in_window & tmr_range;
	assign sys_sel = in_window & ~irq_sel & ~tmr_sel;

	assign sys_bus.off   = cpu_addr[8:0]; // shared offset
	assign irq_bus.off   = cpu_addr[8:0];
	assign tmr_bus.off   = cpu_addr[8:0];
	assign sys_bus.wdata = cpu_din;
	assign irq_bus.wdata = cpu_din;
	assign tmr_bus.wdata = cpu_din;

	assign sys_bus.wr = cpu_wr & sys_sel; // one block at most
	assign irq_bus.wr = cpu_wr & irq_sel;
	assign tmr_bus.wr = cpu_wr & tmr_sel;

	always_comb begin
		cpu_dout = `CLIO_BAD_READ; // unmapped default
		if (irq_sel) begin
			cpu_dout = irq_bus.rdata; // hit already checked
		end else if (tmr_sel && tmr_bus.hit) begin
			cpu_dout = tmr_bus.rdata;
		end else if (sys_sel && sys_bus.hit) begin
			cpu_dout = sys_bus.rdata;
		end
	end

endmodule

//--- clio_sys_regs.sv
/*
 * clio system registers
 * revision, sysbits, vint, status, spare, hdelay, slack and expctl
 */
`timescale 1ns/10ps
`include "clio_cfg.svh"

module clio_sys_regs import clio_pkg::*; (
	input  logic       clk_25m,
	input  logic       reset_n,
	clio_reg_if.block  bus
);

	localparam clio_off_t OFF_REVISION   = 9'h000; // 0x000, read only
	localparam clio_off_t OFF_CSYSBITS   = 9'h001; // 0x004
	localparam clio_off_t OFF_VINT0      = 9'h002; // 0x008
	localparam clio_off_t OFF_VINT1      = 9'h003; // 0x00c
	localparam clio_off_t OFF_CSTATBITS  = 9'h00A; // 0x028
	localparam clio_off_t OFF_SPARE      = 9'h017; // 0x05c
	localparam clio_off_t OFF_HDELAY     = 9'h020; // 0x080
	localparam clio_off_t OFF_SLACK      = 9'h088; // 0x220
	localparam clio_off_t OFF_EXPCTL_SET = 9'h100; // 0x400
	localparam clio_off_t OFF_EXPCTL_CLR = 9'h101; // 0x404

	clio_word_t csysbits;
	clio_word_t vint0;   // vertical line irq 0
	clio_word_t vint1;   // vertical line irq 1
	clio_word_t cstatbits; // bit 0 power on
	clio_word_t spare;
	clio_word_t hdelay;
	clio_word_t expctl;  // expansion bus direction
	logic [`CLIO_SLACK_BITS-1:0] slack; // upper bits dropped

	always_ff @(posedge clk_25m or negedge reset_n) begin
		if (!reset_n) begin
			csysbits  <= '0;
			vint0     <= '0;
			vint1     <= '0;
			cstatbits <= 32'h0000_0001; // por flag
			spare     <= '0;
			hdelay    <= '0;
			slack     <= '0;
			expctl    <= `CLIO_EXPCTL_RESET;
		end else if (bus.wr) begin
			case (bus.off)
				OFF_CSYSBITS:   csysbits  <= bus.wdata;
				OFF_VINT0:      vint0     <= bus.wdata;
				OFF_VINT1:      vint1     <= bus.wdata;
				OFF_CSTATBITS:  cstatbits <= bus.wdata;
				OFF_SPARE:      spare     <= bus.wdata;
				OFF_HDELAY:     hdelay    <= bus.wdata;
				OFF_SLACK:      slack     <= bus.wdata[`CLIO_SLACK_BITS-1:0];
				OFF_EXPCTL_SET: expctl    <= expctl | bus.wdata;  // set bits
				OFF_EXPCTL_CLR: expctl    <= expctl & ~bus.wdata; // clear bits
				default: ; // revision and holes ignore writes
			endcase
		end
	end

	always_comb begin
		bus.hit = 1'b1;
		case (bus.off)
			OFF_REVISION:   bus.rdata = `CLIO_REVISION;
			OFF_CSYSBITS:   bus.rdata = csysbits;
			OFF_VINT0:      bus.rdata = vint0;
			OFF_VINT1:      bus.rdata = vint1;
			OFF_CSTATBITS:  bus.rdata = cstatbits;
			OFF_SPARE:      bus.rdata = spare;
			OFF_HDELAY:     bus.rdata = hdelay;
			OFF_SLACK:      bus.rdata = clio_word_t'(slack); // zero extended
			OFF_EXPCTL_SET,
			OFF_EXPCTL_CLR: bus.rdata = expctl; // same reg both addrs
			default: begin
				bus.rdata = '0;
				bus.hit   = 1'b0; // not ours
			end
		endcase
	end

endmodule

//--- clio_irq_ctrl.sv
/*
 * clio interrupt controller
 * pending and enable banks with set/clear access, mode reg, firq_n out
 */
`timescale 1ns/10ps

module clio_irq_ctrl import clio_pkg::*; (
	input  logic       clk_25m,
	input  logic       reset_n,
	clio_reg_if.block  bus,
	output logic       firq_n
);

	clio_word_t irq0;        // pending bank 0
	clio_word_t irq0_enable; // mask bank 0
	clio_word_t irq1;        // pending bank 1
	clio_word_t irq1_enable; // mask bank 1
	clio_word_t mode;

	// even offset sets, odd offset clears
	always_ff @(posedge clk_25m or negedge reset_n) begin
		if (!reset_n) begin
			irq0        <= '0;
			irq0_enable <= '0;
			irq1        <= '0;
			irq1_enable <= '0;
			mode        <= '0;
		end else if (bus.wr) begin
			case (bus.off)
				9'h010: irq0        <= irq0 | bus.wdata;         // 0x40
				9'h011: irq0        <= irq0 & ~bus.wdata;        // 0x44
				9'h012: irq0_enable <= irq0_enable | bus.wdata;  // 0x48
				9'h013: irq0_enable <= irq0_enable & ~bus.wdata; // 0x4c
				9'h014: mode        <= mode | bus.wdata;         // 0x50
				9'h015: mode        <= mode & ~bus.wdata;        // 0x54
				9'h018: irq1        <= irq1 | bus.wdata;         // 0x60
				9'h019: irq1        <= irq1 & ~bus.wdata;        // 0x64
				9'h01A: irq1_enable <= irq1_enable | bus.wdata;  // 0x68
				9'h01B: irq1_enable <= irq1_enable & ~bus.wdata; // 0x6c
				default: ;
			endcase
		end
	end

	always_comb begin
		bus.hit = 1'b1;
		case (bus.off)
			9'h010, 9'h011: bus.rdata = irq0;
			9'h012, 9'h013: bus.rdata = irq0_enable;
			9'h014, 9'h015: bus.rdata = mode;
			9'h018, 9'h019: bus.rdata = irq1;
			9'h01A, 9'h01B: bus.rdata = irq1_enable;
			default: begin
				bus.rdata = '0;
				bus.hit   = 1'b0; // 0x58/0x5c and gaps go elsewhere
			end
		endcase
	end

	// fiq while any pending bit is also enabled
	assign firq_n = ~(|(irq0 & irq0_enable) | |(irq1 & irq1_enable));

endmodule

//--- clio_timer_regs.sv
/*
 * clio timer registers
 * count/backup word storage and the 64-bit timer control word
 */
`timescale 1ns/10ps
`include "clio_cfg.svh"

module clio_timer_regs import clio_pkg::*; (
	input  logic       clk_25m,
	input  logic       reset_n,
	clio_reg_if.block  bus
);

	localparam int TMR_WORDS = 2 * `CLIO_TIMER_PAIRS; // count, backup per pair
	localparam int IDX_W     = $clog2(TMR_WORDS);
	localparam clio_off_t TMR_FIRST   = clio_off_t'(`CLIO_TMR_BASE >> 2);
	localparam clio_off_t TMR_END     = clio_off_t'(`CLIO_TMR_LAST >> 2);
	localparam clio_off_t TCTRL_FIRST = clio_off_t'(`CLIO_TCTRL_BASE >> 2);
	localparam clio_off_t TCTRL_END   = clio_off_t'(`CLIO_TCTRL_LAST >> 2);

	clio_word_t        tmr_mem [TMR_WORDS]; // even count, odd backup
	logic [63:0]       timer_ctrl;
	logic              tmr_hit;    // offset in count/backup area
	logic              tctrl_hit;  // offset in control word area
	logic [IDX_W-1:0]  tmr_idx;
	logic [1:0]        tctrl_rel;  // bit 1 half, bit 0 clear

	assign tmr_hit   = (bus.off >= TMR_FIRST) && (bus.off <= TMR_END);
	assign tctrl_hit = (bus.off >= TCTRL_FIRST) && (bus.off <= TCTRL_END);
	assign tmr_idx   = IDX_W'(bus.off - TMR_FIRST);
	assign tctrl_rel = 2'(bus.off - TCTRL_FIRST);

	always_ff @(posedge clk_25m or negedge reset_n) begin
		if (!reset_n) begin
			for (int i = 0; i < TMR_WORDS; i++) begin
				tmr_mem[i] <= '0;
			end
			timer_ctrl <= '0;
		end else if (bus.wr) begin
			if (tmr_hit) begin
				tmr_mem[tmr_idx] <= bus.wdata; // plain store
			end else if (tctrl_hit) begin
				case (tctrl_rel)
					2'd0: timer_ctrl[31:0]  <= timer_ctrl[31:0] | bus.wdata;   // 0x200
					2'd1: timer_ctrl[31:0]  <= timer_ctrl[31:0] & ~bus.wdata;  // 0x204
					2'd2: timer_ctrl[63:32] <= timer_ctrl[63:32] | bus.wdata;  // 0x208
					2'd3: timer_ctrl[63:32] <= timer_ctrl[63:32] & ~bus.wdata; // 0x20c
				endcase
			end
		end
	end

	always_comb begin
		bus.hit   = tmr_hit | tctrl_hit;
		bus.rdata = '0;
		if (tmr_hit) begin
			bus.rdata = tmr_mem[tmr_idx];
		end else if (tctrl_hit) begin
			bus.rdata = tctrl_rel[1] ? timer_ctrl[63:32] : timer_ctrl[31:0]; // half by addr
		end
	end

endmodule

//--- clio_top.sv
/*
 * clio register file top
 * cpu facing ports, address decoder and the three register blocks
 */
`timescale 1ns/10ps

module clio_top import clio_pkg::*; (
	input  logic       clk_25m,
	input  logic       reset_n,
	input  clio_addr_t cpu_addr,  // word address
	input  clio_word_t cpu_din,
	input  logic       cpu_wr,    // one cycle per write
	output clio_word_t cpu_dout,  // combinational read
	output logic       firq_n     // to the arm fiq
);

	clio_reg_if sys_bus ();
	clio_reg_if irq_bus ();
	clio_reg_if tmr_bus ();

	clio_addr_decode u_decode (
		.cpu_addr (cpu_addr),
		.cpu_din  (cpu_din),
		.cpu_wr   (cpu_wr),
		.cpu_dout (cpu_dout),
		.sys_bus  (sys_bus.decode),
		.irq_bus  (irq_bus.decode),
		.tmr_bus  (tmr_bus.decode)
	);

	clio_sys_regs u_sys (
		.clk_25m (clk_25m),
		.reset_n (reset_n),
		.bus     (sys_bus.block)
	);

	clio_irq_ctrl u_irq (
		.clk_25m (clk_25m),
		.reset_n (reset_n),
		.bus     (irq_bus.block),
		.firq_n  (firq_n)
	);

	clio_timer_regs u_tmr (
		.clk_25m (clk_25m),
		.reset_n (reset_n),
		.bus     (tmr_bus.block)
	);

endmodule

//--- clio_tb_clock.sv
/*
 * clio testbench clock and reset
 * 25 MHz clock, reset_n held low for the first cycles
 */
`timescale 1ns/10ps

module clio_tb_clock #(
	parameter int PERIOD_NS    = 40, // 25 MHz
	parameter int RESET_CYCLES = 8
) (
	output logic clk_25m,
	output logic reset_n
);

	initial begin
		clk_25m = 1'b0;
		forever #(PERIOD_NS / 2) clk_25m = ~clk_25m; // free running
	end

	initial begin
		reset_n = 1'b0; // in reset from time 0
		repeat (RESET_CYCLES) @(posedge clk_25m);
		reset_n <= 1'b1; // release on a rising edge
	end

endmodule

//--- clio_tb.sv
/*
 * clio register file testbench
 * replays the golden vectors against the DUT, checks cpu_dout and firq_n
 */
`timescale 1ns/10ps

module clio_tb import clio_pkg::*; ();

	localparam int MAX_VECTORS       = 64;
	localparam int RESET_CYCLES      = 8;
	localparam int TIMEOUT_MARGIN    = 20;
	localparam int CYCLES_PER_VECTOR = 2; // a write needs the strobe cycle plus one

	logic       clk_25m;
	logic       reset_n;
	clio_addr_t cpu_addr;
	clio_word_t cpu_din;
	logic       cpu_wr;
	clio_word_t cpu_dout;
	logic       firq_n;

	// golden vectors
	logic [7:0]  vec_op   [MAX_VECTORS]; // W, R or F
	logic [15:0] vec_addr [MAX_VECTORS]; // byte address
	logic [31:0] vec_data [MAX_VECTORS];
	logic [31:0] vec_dout [MAX_VECTORS]; // expected read value
	logic        vec_firq [MAX_VECTORS];
	int          n_vec = 0;

	int cycle_count = 0;
	int cycle_limit = MAX_VECTORS * CYCLES_PER_VECTOR + RESET_CYCLES + TIMEOUT_MARGIN;

	clio_tb_clock #(.PERIOD_NS(40), .RESET_CYCLES(RESET_CYCLES)) u_clock (
		.clk_25m (clk_25m),
		.reset_n (reset_n)
	);

	clio_top uut (
		.clk_25m  (clk_25m),
		.reset_n  (reset_n),
		.cpu_addr (cpu_addr),
		.cpu_din  (cpu_din),
		.cpu_wr   (cpu_wr),
		.cpu_dout (cpu_dout),
		.firq_n   (firq_n)
	);

	// guards against a stuck run
	always @(posedge clk_25m) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count > cycle_limit) begin
			$display("timeout, run took more than %0d cycles", cycle_limit);
			$display("Errors found");
			$fatal(1, "simulation timed out");
		end
	end

	// reads the golden file into the vector arrays
	task automatic load_vectors();
		int               fd;
		int               cnt;
		int               line_no;
		string            load_err;
		logic [8*160-1:0] line_buf;
		logic [7:0]       op;
		logic [15:0]      addr;
		logic [31:0]      data;
		logic [31:0]      dout;
		logic [3:0]       firq;
		load_err = "";
		fd = $fopen("clio_golden.txt", "r");
		if (fd == 0) begin
			load_err = "could not open the golden file clio_golden.txt";
		end else begin
			line_no = 0;
			while (load_err == "" && $fgets(line_buf, fd) != 0) begin
				line_no++;
				op  = 8'h00;
				cnt = $sscanf(line_buf, "%s %h %h %h %h", op, addr, data, dout, firq);
				if (cnt > 0 && op != "#") begin // skip blank and comment lines
					if (cnt != 5 || !(op == "W" || op == "R" || op == "F")) begin
						load_err = $sformatf("golden file line %0d could not be parsed",
							line_no);
					end else if (n_vec >= MAX_VECTORS) begin
						load_err = $sformatf("golden file holds more than %0d vectors",
							MAX_VECTORS);
					end else begin
						vec_op[n_vec]   = op;
						vec_addr[n_vec] = addr;
						vec_data[n_vec] = data;
						vec_dout[n_vec] = dout;
						vec_firq[n_vec] = firq[0];
						n_vec++;
					end
				end
			end
			$fclose(fd);
		end
		if (load_err != "") begin
			$display("%s", load_err);
			$display("Errors found");
			$fatal(1, "bad golden file");
		end
	endtask

	task automatic check_dout(input int i);
		assert (cpu_dout === vec_dout[i]) else begin
			$display("mismatch, time %0t, signal cpu_dout, expected %h, got %h",
				$time, vec_dout[i], cpu_dout);
			$display("Errors found");
			$fatal(1, "read check failed at vector %0d, address %h", i, vec_addr[i]);
		end
	endtask

	task automatic check_firq(input int i);
		assert (firq_n === vec_firq[i]) else begin
			$display("mismatch, time %0t, signal firq_n, expected %b, got %b",
				$time, vec_firq[i], firq_n);
			$display("Errors found");
			$fatal(1, "firq_n check failed at vector %0d", i);
		end
	endtask

	// drive on the rising edge, check on the falling edge
	task automatic apply_vector(input int i);
		@(posedge clk_25m);
		cpu_addr <= vec_addr[i][15:2]; // byte to word address
		cpu_din  <= vec_data[i];
		cpu_wr   <= (vec_op[i] == "W");
		if (vec_op[i] == "W") begin
			@(posedge clk_25m); // write edge
			cpu_wr <= 1'b0;     // strobe is one cycle
		end
		@(negedge clk_25m);
		if (vec_op[i] == "R") begin
			check_dout(i);
		end
		check_firq(i); // every vector
	endtask

	initial begin
		cpu_addr = '0;
		cpu_din  = '0;
		cpu_wr   = 1'b0;
		load_vectors();
		cycle_limit = n_vec * CYCLES_PER_VECTOR + RESET_CYCLES + TIMEOUT_MARGIN;
		wait (reset_n === 1'b1);
		for (int i = 0; i < n_vec; i++) begin
			apply_vector(i);
		end
		if (n_vec > 0) begin
			$display("No errors");
			$finish;
		end else begin
			$display("golden file holds no vectors");
			$display("Errors found");
			$fatal(1, "empty golden file");
		end
	end

endmodule

//--- src.f
+incdir+.
clio_pkg.sv
clio_reg_if.sv
clio_addr_decode.sv
clio_sys_regs.sv
clio_irq_ctrl.sv
clio_timer_regs.sv
clio_top.sv
clio_tb_clock.sv
clio_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build the clio register file testbench with verilator and run it
# a failing check ends the run through $fatal, which gives a nonzero exit
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -j 0 \
	--top-module clio_tb -f src.f -o clio_sim

./obj_dir/clio_sim

//--- clio_golden.txt
# op addr data expected_dout expected_firq, all hex
# W write, R read and check cpu_dout, F check firq_n only
R 0000 00000000 02020000 1
R 0028 00000000 00000001 1
R 0400 00000000 00000080 1
R 0040 00000000 00000000 1
W 0004 A5A55A5A 00000000 1
R 0004 00000000 A5A55A5A 1
W 0008 12345678 00000000 1
R 0008 00000000 12345678 1
W 0080 0000FFFF 00000000 1
R 0080 00000000 0000FFFF 1
W 005C DEADBEEF 00000000 1
R 005C 00000000 DEADBEEF 1
W 0220 FFFFFFFF 00000000 1
R 0220 00000000 000003FF 1
W 0000 FFFFFFFF 00000000 1
R 0000 00000000 02020000 1
W 0050 000000F0 00000000 1
W 0050 0000000F 00000000 1
W 0054 0000003C 00000000 1
R 0050 00000000 000000C3 1
W 0400 00000003 00000000 1
W 0404 00000081 00000000 1
R 0404 00000000 00000002 1
W 0068 00000011 00000000 1
W 006C 00000001 00000000 1
R 0068 00000000 00000010 1
W 0040 00000005 00000000 1
F 0040 00000000 00000000 1
W 0048 00000004 00000000 0
W 0044 00000004 00000000 1
W 0060 00000002 00000000 1
W 0068 00000002 00000000 0
W 0064 00000002 00000000 1
W 0100 11111111 00000000 1
W 0104 22222222 00000000 1
W 0138 77777777 00000000 1
W 013C 88888888 00000000 1
W 017C FFFF0002 00000000 1
R 0100 00000000 11111111 1
R 0104 00000000 22222222 1
R 0138 00000000 77777777 1
R 013C 00000000 88888888 1
R 017C 00000000 FFFF0002 1
R 0178 00000000 00000000 1
W 0200 0000FF00 00000000 1
W 0208 00FF0000 00000000 1
W 0204 00000F00 00000000 1
R 0200 00000000 0000F000 1
R 020C 00000000 00FF0000 1
R 0010 00000000 BADACCE5 1
R 0304 00000000 BADACCE5 1
R 17D0 00000000 BADACCE5 1
R C000 00000000 BADACCE5 1
